// ==== source/lrelu_params.svh ====
`ifndef LRELU_PARAMS_SVH
`define LRELU_PARAMS_SVH

// engine geometry
`define LRELU_GROUPS 2
`define LRELU_UNITS 4

// word widths
`define LRELU_SAMPLE_W 16
`define LRELU_COEF_W 16
`define LRELU_ACC_W 40
`define LRELU_PIXEL_W 8

// coefficients A, B and D are Q7.8
`define LRELU_FRAC_BITS 8

// leaky slope is ALPHA / 2**ALPHA_SHIFT, roughly 0.1
`define LRELU_ALPHA 26
`define LRELU_ALPHA_SHIFT 8

`endif

// ==== source/lrelu_pkg.sv ====
`default_nettype none

`include "lrelu_params.svh"

package lrelu_pkg;

  // scalar words
  typedef logic signed [`LRELU_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`LRELU_COEF_W-1:0] coef_t;
  typedef logic signed [`LRELU_ACC_W-1:0] acc_t;
  typedef logic signed [`LRELU_PIXEL_W-1:0] pixel_t;

  // per group vectors
  typedef sample_t [`LRELU_UNITS-1:0] group_samples_t;
  typedef acc_t [`LRELU_UNITS-1:0] group_acc_t;

  // whole engine, lane index is g*UNITS + u
  typedef sample_t [`LRELU_GROUPS*`LRELU_UNITS-1:0] engine_samples_t;
  typedef pixel_t [`LRELU_GROUPS*`LRELU_UNITS-1:0] engine_pixels_t;
  typedef group_acc_t [`LRELU_GROUPS-1:0] engine_acc_t;

  // one config word carries a coefficient for each group
  typedef coef_t [`LRELU_GROUPS-1:0] cfg_word_t;

  typedef struct packed {
    logic is_max;
    logic is_lrelu;
  } user_t;

  typedef enum logic [1:0] {LOAD_A, LOAD_B, LOAD_D} coef_sel_t;

  typedef struct packed {
    logic      en;
    coef_sel_t sel;
  } coef_write_t;

endpackage

`default_nettype wire

// ==== source/coef_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_loader (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clken,
  input  logic                   cfg_valid,
  input  lrelu_pkg::cfg_word_t   cfg_data,
  output lrelu_pkg::coef_write_t coef_write,
  output lrelu_pkg::cfg_word_t   coef_data
);

  lrelu_pkg::coef_sel_t state;
  lrelu_pkg::coef_sel_t state_next;

  // fixed order A -> B -> D, then back to A
  always_comb begin
    case (state)
      lrelu_pkg::LOAD_A: state_next = lrelu_pkg::LOAD_B;
      lrelu_pkg::LOAD_B: state_next = lrelu_pkg::LOAD_D;
      lrelu_pkg::LOAD_D: state_next = lrelu_pkg::LOAD_A;
      default:           state_next = lrelu_pkg::LOAD_A;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= lrelu_pkg::LOAD_A;
      coef_write.en  <= 1'b0;
      coef_write.sel <= lrelu_pkg::LOAD_A;
    end else if (clken) begin
      // write strobe lands with the slot it was taken in
      coef_write.en  <= cfg_valid;
      coef_write.sel <= state;
      if (cfg_valid) begin
        state <= state_next;
      end
    end
  end

  // word register, only meaningful while coef_write.en is high
  always_ff @(posedge clk) begin
    if (clken && cfg_valid) begin
      coef_data <= cfg_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/lrelu_group.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_params.svh"

module lrelu_group (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     clken,
  input  lrelu_pkg::coef_write_t   coef_write,
  input  lrelu_pkg::coef_t         coef_word,
  input  lrelu_pkg::group_samples_t samples,
  input  logic                     is_lrelu,
  output lrelu_pkg::group_acc_t    acc
);

  lrelu_pkg::coef_t a_coef;
  lrelu_pkg::coef_t b_coef;
  lrelu_pkg::coef_t d_coef;

  lrelu_pkg::group_acc_t p_next;
  lrelu_pkg::group_acc_t p_reg;
  lrelu_pkg::group_acc_t r_next;
  logic                  lrelu_d;

  // coefficient slots, written by the loader
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_coef <= '0;
      b_coef <= '0;
      d_coef <= '0;
    end else if (clken && coef_write.en) begin
      case (coef_write.sel)
        lrelu_pkg::LOAD_A: a_coef <= coef_word;
        lrelu_pkg::LOAD_B: b_coef <= coef_word;
        lrelu_pkg::LOAD_D: d_coef <= coef_word;
        default: ;
      endcase
    end
  end

  // stage 1: p = x*A + B*2^frac
  always_comb begin
    lrelu_pkg::sample_t x;
    lrelu_pkg::acc_t    b_ext;
    b_ext = lrelu_pkg::acc_t'(b_coef) <<< `LRELU_FRAC_BITS;
    for (int u = 0; u < `LRELU_UNITS; u++) begin
      x = samples[u];
      p_next[u] = lrelu_pkg::acc_t'(x) * lrelu_pkg::acc_t'(a_coef) + b_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      p_reg   <= p_next;
      lrelu_d <= is_lrelu;
    end
  end

  // stage 2: leaky slope on negatives, then add D
  always_comb begin
    lrelu_pkg::acc_t p;
    lrelu_pkg::acc_t q;
    lrelu_pkg::acc_t d_ext;
    d_ext = lrelu_pkg::acc_t'(d_coef) <<< `LRELU_FRAC_BITS;
    for (int u = 0; u < `LRELU_UNITS; u++) begin
      p = p_reg[u];
      if (lrelu_d && p[`LRELU_ACC_W-1]) begin
        // arithmetic shift keeps floor rounding
        q = (p * lrelu_pkg::acc_t'(`LRELU_ALPHA)) >>> `LRELU_ALPHA_SHIFT;
      end else begin
        q = p;
      end
      r_next[u] = q + d_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      acc <= r_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/requant_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_params.svh"

module requant_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clken,
  input  lrelu_pkg::engine_acc_t    acc_in,
  input  logic                      s_valid,
  input  lrelu_pkg::user_t          s_user,
  output logic                      m_valid,
  output lrelu_pkg::engine_pixels_t m_data,
  output lrelu_pkg::user_t          m_user
);

  localparam lrelu_pkg::acc_t PIX_MAX = (1 <<< (`LRELU_PIXEL_W - 1)) - 1;
  localparam lrelu_pkg::acc_t PIX_MIN = -(1 <<< (`LRELU_PIXEL_W - 1));

  logic                      valid_d1;
  logic                      valid_d2;
  lrelu_pkg::user_t          user_d1;
  lrelu_pkg::user_t          user_d2;
  lrelu_pkg::engine_pixels_t pix_next;

  // drop the fraction (floor) and clamp each lane
  always_comb begin
    lrelu_pkg::acc_t a;
    lrelu_pkg::acc_t s;
    for (int g = 0; g < `LRELU_GROUPS; g++) begin
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        a = acc_in[g][u];
        s = a >>> `LRELU_FRAC_BITS;
        if (s > PIX_MAX) begin
          pix_next[g*`LRELU_UNITS + u] = lrelu_pkg::pixel_t'(PIX_MAX);
        end else if (s < PIX_MIN) begin
          pix_next[g*`LRELU_UNITS + u] = lrelu_pkg::pixel_t'(PIX_MIN);
        end else begin
          pix_next[g*`LRELU_UNITS + u] = lrelu_pkg::pixel_t'(s);
        end
      end
    end
  end

  // valid and user ride two stages to meet the group output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
      user_d1  <= '0;
      user_d2  <= '0;
      m_valid  <= 1'b0;
      m_data   <= '0;
      m_user   <= '0;
    end else if (clken) begin
      valid_d1 <= s_valid;
      valid_d2 <= valid_d1;
      user_d1  <= s_user;
      user_d2  <= user_d1;
      m_valid  <= valid_d2;
      if (valid_d2) begin
        m_data <= pix_next;
        m_user <= user_d2;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lrelu_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_params.svh"

module lrelu_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clken,
  input  logic                       s_valid,
  input  lrelu_pkg::engine_samples_t s_data,
  input  lrelu_pkg::user_t           s_user,
  input  logic                       cfg_valid,
  input  lrelu_pkg::cfg_word_t       cfg_data,
  output logic                       m_valid,
  output lrelu_pkg::engine_pixels_t  m_data,
  output lrelu_pkg::user_t           m_user
);

  lrelu_pkg::coef_write_t coef_write;
  lrelu_pkg::cfg_word_t   coef_data;
  lrelu_pkg::engine_acc_t group_acc;

  coef_loader u_coef_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .cfg_valid  (cfg_valid),
    .cfg_data   (cfg_data),
    .coef_write (coef_write),
    .coef_data  (coef_data)
  );

  // each group takes its own slice of lanes and of the config word
  for (genvar g = 0; g < `LRELU_GROUPS; g++) begin : g_gen
    lrelu_group u_group (
      .clk        (clk),
      .rst_n      (rst_n),
      .clken      (clken),
      .coef_write (coef_write),
      .coef_word  (coef_data[g]),
      .samples    (s_data[g*`LRELU_UNITS +: `LRELU_UNITS]),
      .is_lrelu   (s_user.is_lrelu),
      .acc        (group_acc[g])
    );
  end

  requant_stage u_requant (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .acc_in  (group_acc),
    .s_valid (s_valid),
    .s_user  (s_user),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_user  (m_user)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_lrelu_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lrelu_params.svh"

module tb_lrelu_engine;

  localparam int LANES      = `LRELU_GROUPS * `LRELU_UNITS;
  localparam int NROWS      = 16;
  localparam int LOADS      = 3;
  localparam int MAX_CYCLES = NROWS * 8 + LOADS * 3 * 2 + 50;

  logic                      clk;
  logic                      rst_n;
  logic                      clken;
  logic                      s_valid;
  lrelu_pkg::engine_samples_t s_data;
  lrelu_pkg::user_t          s_user;
  logic                      cfg_valid;
  lrelu_pkg::cfg_word_t      cfg_data;
  logic                      m_valid;
  lrelu_pkg::engine_pixels_t m_data;
  lrelu_pkg::user_t          m_user;

  // stimulus table and expected results, one entry per sample
  logic                       row_load    [NROWS];
  lrelu_pkg::cfg_word_t       row_a       [NROWS];
  lrelu_pkg::cfg_word_t       row_b       [NROWS];
  lrelu_pkg::cfg_word_t       row_d       [NROWS];
  lrelu_pkg::engine_samples_t row_samples [NROWS];
  lrelu_pkg::user_t           row_user    [NROWS];
  int                         row_stall   [NROWS];
  lrelu_pkg::engine_pixels_t  exp_pix     [NROWS];
  lrelu_pkg::user_t           exp_user    [NROWS];

  int exp_q[$];
  int accept_q[$];
  int errors        = 0;
  int checked       = 0;
  int cycle_count   = 0;
  int enabled_edges = 0;
  int out_row;
  int out_stamp;
  int seed_result;

  lrelu_engine dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_user    (s_user),
    .cfg_valid (cfg_valid),
    .cfg_data  (cfg_data),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_user    (m_user)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // reference: scale, optional leaky slope, offset, floor and clamp
  function automatic lrelu_pkg::pixel_t model_lane(input lrelu_pkg::sample_t x,
                                                   input lrelu_pkg::coef_t a,
                                                   input lrelu_pkg::coef_t b,
                                                   input lrelu_pkg::coef_t d,
                                                   input logic lrelu);
    longint p;
    longint q;
    longint r;
    longint s;
    longint pix_max;
    pix_max = (64'sd1 <<< (`LRELU_PIXEL_W - 1)) - 1;
    p = longint'(x) * longint'(a) + (longint'(b) <<< `LRELU_FRAC_BITS);
    if (lrelu && p < 0) begin
      q = (p * `LRELU_ALPHA) >>> `LRELU_ALPHA_SHIFT;
    end else begin
      q = p;
    end
    r = q + (longint'(d) <<< `LRELU_FRAC_BITS);
    s = r >>> `LRELU_FRAC_BITS;
    if (s > pix_max) s = pix_max;
    else if (s < -pix_max - 1) s = -pix_max - 1;
    return lrelu_pkg::pixel_t'(s);
  endfunction

  task automatic compare_pixels(input string name, input lrelu_pkg::engine_pixels_t expected,
                                input lrelu_pkg::engine_pixels_t actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_user(input string name, input lrelu_pkg::user_t expected,
                              input lrelu_pkg::user_t actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic build_table();
    for (int i = 0; i < NROWS; i++) begin
      row_load[i]  = 1'b0;
      row_stall[i] = 0;
      row_a[i]     = '0;
      row_b[i]     = '0;
      row_d[i]     = '0;
      row_user[i]  = '0;
      for (int k = 0; k < LANES; k++) begin
        row_samples[i][k] = lrelu_pkg::sample_t'(int'($urandom_range(4095)) - 2048);
      end
    end
    // row 0 runs before any coefficient is loaded
    row_user[0] = lrelu_pkg::user_t'(2'b11);
    // rows 1 and 2: linear then leaky, groups differ
    row_load[1] = 1'b1;
    row_a[1][0] = 16'sd256;
    row_a[1][1] = 16'sd96;
    row_b[1][0] = 16'sd3;
    row_b[1][1] = -16'sd5;
    row_d[1][0] = -16'sd1;
    row_d[1][1] = 16'sd2;
    for (int k = 0; k < LANES; k++) begin
      row_samples[1][k] = lrelu_pkg::sample_t'(k * 29 - 100);
      row_samples[2][k] = lrelu_pkg::sample_t'(k * 29 - 100);
      // rows 3 and 4 push both ends of the pixel range
      row_samples[3][k] = lrelu_pkg::sample_t'((k % 2 == 1) ? -30000 + 100 * k : 30000 - 100 * k);
      row_samples[4][k] = row_samples[3][k];
    end
    row_user[2]  = lrelu_pkg::user_t'(2'b01);
    row_stall[2] = 2;
    row_user[4]  = lrelu_pkg::user_t'(2'b01);
    row_stall[4] = 1;
    // second full set, the fourth word goes back to A
    row_load[5] = 1'b1;
    row_a[5][0] = -16'sd200;
    row_a[5][1] = 16'sd512;
    row_b[5][0] = 16'sd10;
    row_b[5][1] = -16'sd20;
    row_d[5][0] = -16'sd3;
    row_d[5][1] = 16'sd7;
    row_user[5] = lrelu_pkg::user_t'(2'b10);
    for (int i = 6; i < NROWS; i++) begin
      row_user[i]  = lrelu_pkg::user_t'($urandom_range(3));
      row_stall[i] = (i == 11) ? 0 : int'($urandom_range(3));
    end
    // random third set
    row_load[11] = 1'b1;
    for (int g = 0; g < `LRELU_GROUPS; g++) begin
      row_a[11][g] = lrelu_pkg::coef_t'(int'($urandom_range(1023)) - 512);
      row_b[11][g] = lrelu_pkg::coef_t'(int'($urandom_range(255)) - 128);
      row_d[11][g] = lrelu_pkg::coef_t'(int'($urandom_range(255)) - 128);
    end
    // active set carries forward until the next load
    for (int i = 1; i < NROWS; i++) begin
      if (!row_load[i]) begin
        row_a[i] = row_a[i-1];
        row_b[i] = row_b[i-1];
        row_d[i] = row_d[i-1];
      end
    end
    for (int i = 0; i < NROWS; i++) begin
      exp_user[i] = row_user[i];
      for (int g = 0; g < `LRELU_GROUPS; g++) begin
        for (int u = 0; u < `LRELU_UNITS; u++) begin
          exp_pix[i][g*`LRELU_UNITS + u] = model_lane(row_samples[i][g*`LRELU_UNITS + u],
            row_a[i][g], row_b[i][g], row_d[i][g], row_user[i].is_lrelu);
        end
      end
    end
  endtask

  // drain the pipeline, then send A, B and D
  task automatic load_config(input int row);
    @(posedge clk);
    s_valid <= 1'b0;
    clken   <= 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_data  <= row_a[row];
    @(posedge clk);
    cfg_data <= row_b[row];
    @(posedge clk);
    cfg_data <= row_d[row];
    @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  task automatic drive_row(input int row);
    // clken low with junk data that must not be taken
    for (int n = 0; n < row_stall[row]; n++) begin
      @(posedge clk);
      clken   <= 1'b0;
      s_valid <= 1'b1;
      s_data  <= ~row_samples[row];
    end
    @(posedge clk);
    clken   <= 1'b1;
    s_valid <= 1'b1;
    s_data  <= row_samples[row];
    s_user  <= row_user[row];
    exp_q.push_back(row);
  endtask

  // output monitor, latency counted in enabled edges
  always @(posedge clk) begin
    if (rst_n && clken) begin
      if (s_valid) accept_q.push_back(enabled_edges);
      if (m_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output at t=%0t with no sample pending", $time);
        end else begin
          out_row   = exp_q.pop_front();
          out_stamp = accept_q.pop_front();
          if (enabled_edges != out_stamp + 3) begin
            errors++;
            $display("row %0d came out %0d enabled cycles after its input instead of 3",
                     out_row, enabled_edges - out_stamp);
          end
          compare_pixels("m_data", exp_pix[out_row], m_data);
          compare_user("m_user", exp_user[out_row], m_user);
          checked++;
        end
      end
      enabled_edges++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d outputs pending", cycle_count, exp_q.size());
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed_result = $urandom(32'h1227_3fb9);
    rst_n     = 1'b0;
    clken     = 1'b1;
    s_valid   = 1'b0;
    s_data    = '0;
    s_user    = '0;
    cfg_valid = 1'b0;
    cfg_data  = '0;
    build_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // idle outputs straight after reset
    @(negedge clk);
    compare_flag("m_valid", 1'b0, m_valid);
    compare_pixels("m_data", '0, m_data);
    compare_user("m_user", '0, m_user);
    for (int i = 0; i < NROWS; i++) begin
      if (row_load[i]) load_config(i);
      drive_row(i);
    end
    @(posedge clk);
    s_valid <= 1'b0;
    clken   <= 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(posedge clk);
    if (checked != NROWS) begin
      errors++;
      $display("expected %0d outputs but saw %0d", NROWS, checked);
    end
    $display("errors: %0d, outputs checked: %0d of %0d", errors, checked, NROWS);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/lrelu_pkg.sv
source/coef_loader.sv
source/lrelu_group.sv
source/requant_stage.sv
source/lrelu_engine.sv
testbench/tb_lrelu_engine.sv

// ==== Bender.yml ====
package:
  name: lrelu_engine

sources:
  - include_dirs:
      - source
    files:
      - source/lrelu_pkg.sv
      - source/coef_loader.sv
      - source/lrelu_group.sv
      - source/requant_stage.sv
      - source/lrelu_engine.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/tb_lrelu_engine.sv
